// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_segre_core -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_segre_core)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: segre_core.sv
`timescale 1ns/10ps

module segre_core
    import segre_isa_pkg::*, segre_core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 instr_valid_i,
    input  logic [WORD_SIZE-1:0] instr_i,
    input  logic [WORD_SIZE-1:0] pc_i,
    output logic                 wb_valid_o,
    output logic [REG_SIZE-1:0]  wb_addr_o,
    output logic [WORD_SIZE-1:0] wb_data_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output logic [WORD_SIZE-1:0] mem_addr_o,
    output logic [WORD_SIZE-1:0] mem_wdata_o,
    output memop_data_type_e     mem_type_o,
    output logic                 mem_sign_ext_o,
    output logic                 br_taken_o,
    output logic [WORD_SIZE-1:0] br_target_o,
    output logic                 illegal_o
);

logic [WORD_SIZE-1:0] rdata_a;
logic [WORD_SIZE-1:0] rdata_b;

segre_ctrl_if ctrl_if0 ();

segre_decode decode0 (
    .instr_i (instr_i),
    .rst_i   (rst_i),
    .ctrl_o  (ctrl_if0)
);

segre_rf #(
    .NUM_REGS (NUM_REGS)
) rf0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (ctrl_if0.raddr_a),
    .raddr_b_i (ctrl_if0.raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (wb_valid_o), // Writeback at end of the result cycle
    .waddr_i   (wb_addr_o),
    .wdata_i   (wb_data_o)
);

segre_ex ex0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (instr_valid_i),
    .pc_i           (pc_i),
    .ctrl_i         (ctrl_if0),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .wb_valid_o     (wb_valid_o),
    .wb_addr_o      (wb_addr_o),
    .wb_data_o      (wb_data_o),
    .mem_req_o      (mem_req_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_type_o     (mem_type_o),
    .mem_sign_ext_o (mem_sign_ext_o),
    .br_taken_o     (br_taken_o),
    .br_target_o    (br_target_o),
    .illegal_o      (illegal_o)
);

endmodule

// File: segre_core_pkg.sv
package segre_core_pkg;

localparam int WORD_SIZE = 32;
localparam int REG_SIZE  = 5;

typedef enum logic [1:0] {
    ALU_A_REG,
    ALU_A_PC,
    ALU_A_IMM
} alu_src_a_e;

typedef enum logic {ALU_B_REG, ALU_B_IMM} alu_src_b_e;

typedef enum logic {IMM_A_ZERO, IMM_A_RS1} alu_imm_a_e;

typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_U,
    IMM_B_J,
    IMM_B_B
} alu_imm_b_e;

// Compare operands, or PC and 4 for the link value
typedef enum logic {BR_A_REG, BR_A_PC} br_src_a_e;

typedef enum logic {BR_B_REG, BR_B_FOUR} br_src_b_e;

endpackage

// File: segre_ctrl_if.sv
`timescale 1ns/10ps

interface segre_ctrl_if
    import segre_isa_pkg::*, segre_core_pkg::*;
();

    logic [WORD_SIZE-1:0] imm_i;
    logic [WORD_SIZE-1:0] imm_s;
    logic [WORD_SIZE-1:0] imm_u;
    logic [WORD_SIZE-1:0] imm_j;
    logic [WORD_SIZE-1:0] imm_b;
    logic [WORD_SIZE-1:0] zimm_rs1;
    alu_imm_a_e           imm_a_sel;
    alu_imm_b_e           imm_b_sel;
    alu_src_a_e           src_a_sel;
    alu_src_b_e           src_b_sel;
    br_src_a_e            br_a_sel;
    br_src_b_e            br_b_sel;
    alu_opcode_e          alu_opcode;
    logic [REG_SIZE-1:0]  raddr_a;
    logic [REG_SIZE-1:0]  raddr_b;
    logic [REG_SIZE-1:0]  waddr;
    logic                 rf_we;
    logic                 memop_rd;
    logic                 memop_wr;
    memop_data_type_e     memop_type;
    logic                 memop_sign_ext;
    logic                 is_branch_jal;
    logic                 illegal;

    modport dec (
        output imm_i, imm_s, imm_u, imm_j, imm_b, zimm_rs1,
        output imm_a_sel, imm_b_sel, src_a_sel, src_b_sel, br_a_sel, br_b_sel,
        output alu_opcode, raddr_a, raddr_b, waddr, rf_we,
        output memop_rd, memop_wr, memop_type, memop_sign_ext, is_branch_jal, illegal
    );

    modport ex (
        input imm_i, imm_s, imm_u, imm_j, imm_b, zimm_rs1,
        input imm_a_sel, imm_b_sel, src_a_sel, src_b_sel, br_a_sel, br_b_sel,
        input alu_opcode, raddr_a, raddr_b, waddr, rf_we,
        input memop_rd, memop_wr, memop_type, memop_sign_ext, is_branch_jal, illegal
    );

endinterface

// File: segre_decode.sv
`timescale 1ns/10ps

module segre_decode
    import segre_isa_pkg::*, segre_core_pkg::*;
(
    input logic [WORD_SIZE-1:0] instr_i,
    input logic                 rst_i,
    segre_ctrl_if.dec           ctrl_o
);

opcode_e    opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic       illegal_op;
logic       illegal_alu;

assign opcode = opcode_e'(instr_i[6:0]);
assign funct3 = instr_i[14:12];
assign funct7 = instr_i[31:25];

assign ctrl_o.imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
assign ctrl_o.imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign ctrl_o.imm_u = {instr_i[31:12], 12'b0};
assign ctrl_o.imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
assign ctrl_o.imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
assign ctrl_o.zimm_rs1 = {{(WORD_SIZE-REG_SIZE){1'b0}}, instr_i[19:15]};

assign ctrl_o.raddr_a = instr_i[19:15];
assign ctrl_o.raddr_b = instr_i[24:20];
assign ctrl_o.waddr   = instr_i[11:7];

assign ctrl_o.illegal = ~rst_i & (illegal_op | illegal_alu); // Quiet while in reset

always_comb begin
    ctrl_o.rf_we          = 1'b0;
    ctrl_o.memop_rd       = 1'b0;
    ctrl_o.memop_wr       = 1'b0;
    ctrl_o.memop_type     = WORD;
    ctrl_o.memop_sign_ext = 1'b0;
    ctrl_o.is_branch_jal  = 1'b0;
    illegal_op            = 1'b0;

    unique case (opcode)
        OPCODE_LUI, OPCODE_AUIPC, OPCODE_OP_IMM, OPCODE_OP: begin
            ctrl_o.rf_we = 1'b1;
        end
        OPCODE_LOAD: begin
            ctrl_o.memop_rd       = 1'b1; // No load data returns, so no write
            ctrl_o.memop_sign_ext = ~funct3[2];
            unique case (funct3)
                3'b000, 3'b100: ctrl_o.memop_type = BYTE;
                3'b001, 3'b101: ctrl_o.memop_type = HALF;
                3'b010:         ctrl_o.memop_type = WORD;
                default:        illegal_op = 1'b1;
            endcase
        end
        OPCODE_STORE: begin
            ctrl_o.memop_wr = 1'b1;
            unique case (funct3)
                3'b000:  ctrl_o.memop_type = BYTE;
                3'b001:  ctrl_o.memop_type = HALF;
                3'b010:  ctrl_o.memop_type = WORD;
                default: illegal_op = 1'b1;
            endcase
        end
        OPCODE_JAL: begin
            ctrl_o.rf_we         = 1'b1;
            ctrl_o.is_branch_jal = 1'b1;
        end
        OPCODE_JALR: begin
            ctrl_o.rf_we         = 1'b1;
            ctrl_o.is_branch_jal = 1'b1;
            illegal_op           = (funct3 != 3'b000);
        end
        OPCODE_BRANCH: begin
            ctrl_o.is_branch_jal = 1'b1;
        end
        default: illegal_op = 1'b1; // SYSTEM and unknown opcodes
    endcase
end

always_comb begin
    ctrl_o.src_a_sel  = ALU_A_REG;
    ctrl_o.src_b_sel  = ALU_B_REG;
    ctrl_o.imm_a_sel  = IMM_A_ZERO;
    ctrl_o.imm_b_sel  = IMM_B_I;
    ctrl_o.br_a_sel   = BR_A_REG;
    ctrl_o.br_b_sel   = BR_B_REG;
    ctrl_o.alu_opcode = ALU_ADD;
    illegal_alu       = 1'b0;

    unique case (opcode)
        OPCODE_LUI: begin
            ctrl_o.src_a_sel = ALU_A_IMM; // Zero plus U immediate
            ctrl_o.src_b_sel = ALU_B_IMM;
            ctrl_o.imm_b_sel = IMM_B_U;
        end
        OPCODE_AUIPC: begin
            ctrl_o.src_a_sel = ALU_A_PC;
            ctrl_o.src_b_sel = ALU_B_IMM;
            ctrl_o.imm_b_sel = IMM_B_U;
        end
        OPCODE_OP_IMM: begin
            ctrl_o.src_b_sel = ALU_B_IMM;
            unique case (funct3)
                3'b000: ctrl_o.alu_opcode = ALU_ADD;
                3'b010: ctrl_o.alu_opcode = ALU_SLT;
                3'b011: ctrl_o.alu_opcode = ALU_SLTU;
                3'b100: ctrl_o.alu_opcode = ALU_XOR;
                3'b110: ctrl_o.alu_opcode = ALU_OR;
                3'b111: ctrl_o.alu_opcode = ALU_AND;
                3'b001: begin
                    ctrl_o.alu_opcode = ALU_SLL;
                    illegal_alu       = (funct7 != FUNCT7_BASE);
                end
                default: begin
                    if (funct7 == FUNCT7_BASE) ctrl_o.alu_opcode = ALU_SRL;
                    else if (funct7 == FUNCT7_ALT) ctrl_o.alu_opcode = ALU_SRA;
                    else illegal_alu = 1'b1;
                end
            endcase
        end
        OPCODE_OP: begin
            unique case ({funct7, funct3})
                {FUNCT7_BASE, 3'b000}: ctrl_o.alu_opcode = ALU_ADD;
                {FUNCT7_ALT,  3'b000}: ctrl_o.alu_opcode = ALU_SUB;
                {FUNCT7_BASE, 3'b001}: ctrl_o.alu_opcode = ALU_SLL;
                {FUNCT7_BASE, 3'b010}: ctrl_o.alu_opcode = ALU_SLT;
                {FUNCT7_BASE, 3'b011}: ctrl_o.alu_opcode = ALU_SLTU;
                {FUNCT7_BASE, 3'b100}: ctrl_o.alu_opcode = ALU_XOR;
                {FUNCT7_BASE, 3'b101}: ctrl_o.alu_opcode = ALU_SRL;
                {FUNCT7_ALT,  3'b101}: ctrl_o.alu_opcode = ALU_SRA;
                {FUNCT7_BASE, 3'b110}: ctrl_o.alu_opcode = ALU_OR;
                {FUNCT7_BASE, 3'b111}: ctrl_o.alu_opcode = ALU_AND;
                default:               illegal_alu = 1'b1; // M extension too
            endcase
        end
        OPCODE_LOAD: begin
            ctrl_o.src_b_sel = ALU_B_IMM;
        end
        OPCODE_STORE: begin
            ctrl_o.src_b_sel = ALU_B_IMM;
            ctrl_o.imm_b_sel = IMM_B_S;
        end
        OPCODE_JAL: begin
            ctrl_o.src_a_sel  = ALU_A_PC;
            ctrl_o.src_b_sel  = ALU_B_IMM;
            ctrl_o.imm_b_sel  = IMM_B_J;
            ctrl_o.br_a_sel   = BR_A_PC;
            ctrl_o.br_b_sel   = BR_B_FOUR;
            ctrl_o.alu_opcode = ALU_JAL;
        end
        OPCODE_JALR: begin
            ctrl_o.src_b_sel  = ALU_B_IMM;
            ctrl_o.br_a_sel   = BR_A_PC;
            ctrl_o.br_b_sel   = BR_B_FOUR;
            ctrl_o.alu_opcode = ALU_JALR;
        end
        OPCODE_BRANCH: begin
            ctrl_o.src_a_sel = ALU_A_PC; // ALU forms the target
            ctrl_o.src_b_sel = ALU_B_IMM;
            ctrl_o.imm_b_sel = IMM_B_B;
            unique case (funct3)
                3'b000:  ctrl_o.alu_opcode = ALU_BEQ;
                3'b001:  ctrl_o.alu_opcode = ALU_BNE;
                3'b100:  ctrl_o.alu_opcode = ALU_BLT;
                3'b101:  ctrl_o.alu_opcode = ALU_BGE;
                3'b110:  ctrl_o.alu_opcode = ALU_BLTU;
                3'b111:  ctrl_o.alu_opcode = ALU_BGEU;
                default: illegal_alu = 1'b1;
            endcase
        end
        default: ;
    endcase
end

endmodule

// File: segre_ex.sv
`timescale 1ns/10ps

module segre_ex
    import segre_isa_pkg::*, segre_core_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  logic [WORD_SIZE-1:0] pc_i,
    segre_ctrl_if.ex             ctrl_i,
    input  logic [WORD_SIZE-1:0] rdata_a_i,
    input  logic [WORD_SIZE-1:0] rdata_b_i,
    output logic                 wb_valid_o,
    output logic [REG_SIZE-1:0]  wb_addr_o,
    output logic [WORD_SIZE-1:0] wb_data_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output logic [WORD_SIZE-1:0] mem_addr_o,
    output logic [WORD_SIZE-1:0] mem_wdata_o,
    output memop_data_type_e     mem_type_o,
    output logic                 mem_sign_ext_o,
    output logic                 br_taken_o,
    output logic [WORD_SIZE-1:0] br_target_o,
    output logic                 illegal_o
);

localparam int SHAMT_W = $clog2(WORD_SIZE);

logic [WORD_SIZE-1:0] rs1;
logic [WORD_SIZE-1:0] rs2;
logic [WORD_SIZE-1:0] imm_a;
logic [WORD_SIZE-1:0] imm_b;
logic [WORD_SIZE-1:0] alu_a;
logic [WORD_SIZE-1:0] alu_b;
logic [WORD_SIZE-1:0] br_a;
logic [WORD_SIZE-1:0] br_b;
logic [WORD_SIZE-1:0] alu_res;
logic [WORD_SIZE-1:0] link;
logic [SHAMT_W-1:0]   shamt;
logic                 br_cond;
logic                 accept;

// Previous result overrides a stale register read
assign rs1 = (wb_valid_o && wb_addr_o == ctrl_i.raddr_a) ? wb_data_o : rdata_a_i;
assign rs2 = (wb_valid_o && wb_addr_o == ctrl_i.raddr_b) ? wb_data_o : rdata_b_i;

assign imm_a = (ctrl_i.imm_a_sel == IMM_A_RS1) ? ctrl_i.zimm_rs1 : '0;

always_comb begin
    unique case (ctrl_i.imm_b_sel)
        IMM_B_S: imm_b = ctrl_i.imm_s;
        IMM_B_U: imm_b = ctrl_i.imm_u;
        IMM_B_J: imm_b = ctrl_i.imm_j;
        IMM_B_B: imm_b = ctrl_i.imm_b;
        default: imm_b = ctrl_i.imm_i;
    endcase

    unique case (ctrl_i.src_a_sel)
        ALU_A_PC:  alu_a = pc_i;
        ALU_A_IMM: alu_a = imm_a;
        default:   alu_a = rs1;
    endcase
end

assign alu_b = (ctrl_i.src_b_sel == ALU_B_IMM) ? imm_b : rs2;
assign br_a  = (ctrl_i.br_a_sel == BR_A_PC) ? pc_i : rs1;
assign br_b  = (ctrl_i.br_b_sel == BR_B_FOUR) ? WORD_SIZE'(4) : rs2;
assign link  = br_a + br_b; // PC plus 4 for JAL and JALR
assign shamt = alu_b[SHAMT_W-1:0];

always_comb begin
    unique case (ctrl_i.alu_opcode)
        ALU_SUB:  alu_res = alu_a - alu_b;
        ALU_SLL:  alu_res = alu_a << shamt;
        ALU_SLT:  alu_res = {{(WORD_SIZE-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
        ALU_SLTU: alu_res = {{(WORD_SIZE-1){1'b0}}, alu_a < alu_b};
        ALU_XOR:  alu_res = alu_a ^ alu_b;
        ALU_SRL:  alu_res = alu_a >> shamt;
        ALU_SRA:  alu_res = $unsigned($signed(alu_a) >>> shamt);
        ALU_OR:   alu_res = alu_a | alu_b;
        ALU_AND:  alu_res = alu_a & alu_b;
        ALU_JALR: alu_res = (alu_a + alu_b) & ~WORD_SIZE'(1);
        default:  alu_res = alu_a + alu_b; // ADD, JAL and branch targets
    endcase

    unique case (ctrl_i.alu_opcode)
        ALU_JAL, ALU_JALR: br_cond = 1'b1;
        ALU_BEQ:  br_cond = (br_a == br_b);
        ALU_BNE:  br_cond = (br_a != br_b);
        ALU_BLT:  br_cond = ($signed(br_a) < $signed(br_b));
        ALU_BGE:  br_cond = ($signed(br_a) >= $signed(br_b));
        ALU_BLTU: br_cond = (br_a < br_b);
        ALU_BGEU: br_cond = (br_a >= br_b);
        default:  br_cond = 1'b0;
    endcase
end

assign accept = valid_i & ~ctrl_i.illegal;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wb_valid_o <= 1'b0;
        mem_req_o  <= 1'b0;
        mem_we_o   <= 1'b0;
        br_taken_o <= 1'b0;
        illegal_o  <= 1'b0;
    end else begin
        wb_valid_o <= accept & ctrl_i.rf_we & (ctrl_i.waddr != '0);
        mem_req_o  <= accept & (ctrl_i.memop_rd | ctrl_i.memop_wr);
        mem_we_o   <= accept & ctrl_i.memop_wr;
        br_taken_o <= accept & ctrl_i.is_branch_jal & br_cond;
        illegal_o  <= valid_i & ctrl_i.illegal;
    end
end

always_ff @(posedge clk_i) begin
    if (valid_i) begin
        wb_addr_o      <= ctrl_i.waddr;
        wb_data_o      <= ctrl_i.is_branch_jal ? link : alu_res;
        mem_addr_o     <= alu_res; // rs1 plus immediate
        mem_wdata_o    <= rs2;
        mem_type_o     <= ctrl_i.memop_type;
        mem_sign_ext_o <= ctrl_i.memop_sign_ext;
        br_target_o    <= alu_res;
    end
end

endmodule

// File: segre_isa_pkg.sv
package segre_isa_pkg;

// RV32I major opcodes
typedef enum logic [6:0] {
    OPCODE_LUI    = 7'b011_0111,
    OPCODE_AUIPC  = 7'b001_0111,
    OPCODE_JAL    = 7'b110_1111,
    OPCODE_JALR   = 7'b110_0111,
    OPCODE_BRANCH = 7'b110_0011,
    OPCODE_LOAD   = 7'b000_0011,
    OPCODE_STORE  = 7'b010_0011,
    OPCODE_OP_IMM = 7'b001_0011,
    OPCODE_OP     = 7'b011_0011,
    OPCODE_SYSTEM = 7'b111_0011
} opcode_e;

typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_JAL,
    ALU_JALR,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
} alu_opcode_e;

typedef enum logic [1:0] {BYTE, HALF, WORD} memop_data_type_e;

localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000; // SUB and SRA(I)

endpackage

// File: segre_rf.sv
`timescale 1ns/10ps

module segre_rf
    import segre_core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [REG_SIZE-1:0]  raddr_a_i,
    input  logic [REG_SIZE-1:0]  raddr_b_i,
    output logic [WORD_SIZE-1:0] rdata_a_o,
    output logic [WORD_SIZE-1:0] rdata_b_o,
    input  logic                 we_i,
    input  logic [REG_SIZE-1:0]  waddr_i,
    input  logic [WORD_SIZE-1:0] wdata_i
);

logic [WORD_SIZE-1:0] regs [NUM_REGS];

// Addresses past the depth read as zero (RV32E build)
assign rdata_a_o = (raddr_a_i != '0 && raddr_a_i < NUM_REGS) ? regs[raddr_a_i] : '0;
assign rdata_b_o = (raddr_b_i != '0 && raddr_b_i < NUM_REGS) ? regs[raddr_b_i] : '0;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (we_i && waddr_i != '0 && waddr_i < NUM_REGS) begin
        regs[waddr_i] <= wdata_i; // x0 never written
    end
end

endmodule

// File: tb_segre_ref.svh
`ifndef TB_SEGRE_REF_SVH
`define TB_SEGRE_REF_SVH

typedef struct packed {
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        req;
    logic        mwe;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [1:0]  mtype;
    logic        sext;
    logic        taken;
    logic [31:0] target;
    logic        ill;
} expect_t;

logic [31:0] shadow [32]; // Architectural view, x0 never written
expect_t     pend;

function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
endfunction

function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
endfunction

function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
endfunction

// Integer result by funct3, alt selects SUB or SRA
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

// Expected outputs one cycle after ins, shadow updated on a write
task automatic predict_outputs(input logic [31:0] ins, input logic [31:0] pc_val);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        wr;
    logic        legal;

    f7    = ins[31:25];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = shadow[ins[19:15]];
    b     = shadow[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    res   = '0;
    wr    = 1'b0;
    legal = 1'b1;
    pend  = '0;
    case (ins[6:0])
        OPCODE_LUI: begin
            wr  = 1'b1;
            res = {ins[31:12], 12'b0};
        end
        OPCODE_AUIPC: begin
            wr  = 1'b1;
            res = pc_val + {ins[31:12], 12'b0};
        end
        OPCODE_OP_IMM: begin
            wr    = 1'b1;
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            res   = alu_result(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
        end
        OPCODE_OP: begin
            wr    = 1'b1;
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            res   = alu_result(f3, f7 == 7'h20, a, b);
        end
        OPCODE_LOAD: begin
            legal      = (f3 != 3'd3 && f3 < 3'd6);
            pend.req   = 1'b1;
            pend.addr  = a + imm_i;
            pend.mtype = f3[1:0];
            pend.sext  = ~f3[2];
        end
        OPCODE_STORE: begin
            legal      = (f3 < 3'd3);
            pend.req   = 1'b1;
            pend.mwe   = 1'b1;
            pend.addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            pend.wdata = b;
            pend.mtype = f3[1:0];
        end
        OPCODE_BRANCH: begin
            legal       = (f3 != 3'd2 && f3 != 3'd3);
            pend.taken  = branch_taken(f3, a, b);
            pend.target = pc_val + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        OPCODE_JAL: begin
            wr          = 1'b1;
            res         = pc_val + 32'd4;
            pend.taken  = 1'b1;
            pend.target = pc_val + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        OPCODE_JALR: begin
            legal       = (f3 == 3'd0);
            wr          = 1'b1;
            res         = pc_val + 32'd4;
            pend.taken  = 1'b1;
            pend.target = (a + imm_i) & ~32'd1;
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        pend     = '0;
        pend.ill = 1'b1;
    end else if (wr && rd != 5'd0) begin
        pend.we    = 1'b1;
        pend.rd    = rd;
        pend.data  = res;
        shadow[rd] = res;
    end
endtask

`endif

// File: tb_segre_core.sv
`timescale 1ns/10ps

module tb_segre_core
    import segre_isa_pkg::*;
();

localparam int CLK_PERIOD = 40;
localparam int NUM_INSTR  = 146; // Reset and driven cycles
localparam int TIMEOUT_NS = (NUM_INSTR + 20) * CLK_PERIOD;

logic        clk;
logic        rst;
logic        instr_valid;
logic [31:0] instr;
logic [31:0] pc;
logic        wb_valid;
logic [4:0]  wb_addr;
logic [31:0] wb_data;
logic        mem_req;
logic        mem_we;
logic [31:0] mem_addr;
logic [31:0] mem_wdata;
logic [1:0]  mem_type;
logic        mem_sign_ext;
logic        br_taken;
logic [31:0] br_target;
logic        illegal;
logic [31:0] cur_pc;
integer      seed = 80;
string       pend_name;
string       chk_name;

`include "tb_segre_ref.svh"

expect_t chk; // Expectation for what the outputs show this cycle

segre_core #(
    .NUM_REGS (32)
) dut0 (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .wb_valid_o     (wb_valid),
    .wb_addr_o      (wb_addr),
    .wb_data_o      (wb_data),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_type_o     (mem_type),
    .mem_sign_ext_o (mem_sign_ext),
    .br_taken_o     (br_taken),
    .br_target_o    (br_target),
    .illegal_o      (illegal)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the stimulus did not finish in %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
end

task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    $display("ERROR %s: %s expected %08h actual %08h", chk_name, sig, exp_val, act_val);
    $display("Test failed");
    $fatal(1, "Stopping at first mismatch");
endtask

// Outputs settled by mid-cycle
always @(negedge clk) begin
    if (!rst) begin
        assert (wb_valid == chk.we)
            else report_mismatch("wb_valid_o", 32'(chk.we), 32'(wb_valid));
        assert (mem_req == chk.req)
            else report_mismatch("mem_req_o", 32'(chk.req), 32'(mem_req));
        assert (mem_we == chk.mwe)
            else report_mismatch("mem_we_o", 32'(chk.mwe), 32'(mem_we));
        assert (br_taken == chk.taken)
            else report_mismatch("br_taken_o", 32'(chk.taken), 32'(br_taken));
        assert (illegal == chk.ill)
            else report_mismatch("illegal_o", 32'(chk.ill), 32'(illegal));
        if (chk.we) begin
            assert (wb_addr == chk.rd)
                else report_mismatch("wb_addr_o", 32'(chk.rd), 32'(wb_addr));
            assert (wb_data == chk.data) else report_mismatch("wb_data_o", chk.data, wb_data);
        end
        if (chk.req) begin
            assert (mem_addr == chk.addr) else report_mismatch("mem_addr_o", chk.addr, mem_addr);
            assert (mem_type == chk.mtype)
                else report_mismatch("mem_type_o", 32'(chk.mtype), 32'(mem_type));
            assert (mem_sign_ext == chk.sext)
                else report_mismatch("mem_sign_ext_o", 32'(chk.sext), 32'(mem_sign_ext));
        end
        if (chk.mwe) begin
            assert (mem_wdata == chk.wdata)
                else report_mismatch("mem_wdata_o", chk.wdata, mem_wdata);
        end
        if (chk.taken) begin
            assert (br_target == chk.target)
                else report_mismatch("br_target_o", chk.target, br_target);
        end
    end
end

task automatic drive_cycle(input logic vld, input logic [31:0] ins, input string name);
    @(posedge clk);
    #2;
    chk         = pend; // Previous instruction now visible
    chk_name    = pend_name;
    instr_valid = vld;
    instr       = ins;
    pc          = cur_pc;
    pend_name   = name;
    if (vld) begin
        predict_outputs(ins, cur_pc);
    end else begin
        pend = '0;
    end
    cur_pc = cur_pc + 32'd4;
endtask

initial begin
    logic [31:0] ins;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  last_rd;
    int          f3;
    int          alt;
    int          use_imm;

    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    cur_pc      = 32'h0000_1000;
    pend        = '0;
    pend_name   = "reset";
    chk         = '0;
    chk_name    = "reset";
    foreach (shadow[i]) begin
        shadow[i] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    drive_cycle(1'b0, '0, "idle_after_reset");
    drive_cycle(1'b0, '0, "idle_after_reset");

    // Random register contents via LUI then ADDI
    for (int r = 1; r < 32; r++) begin
        drive_cycle(1'b1, u_format(20'($random(seed)), 5'(r), OPCODE_LUI), "init_lui");
        ins = i_format(12'($random(seed)), 5'(r), 3'd0, 5'(r), OPCODE_OP_IMM);
        drive_cycle(1'b1, ins, "init_addi");
    end
    drive_cycle(1'b0, '0, "idle");

    last_rd = 5'd1;
    for (int k = 0; k < 64; k++) begin
        f3      = k % 8;
        alt     = (k / 8) % 2;
        use_imm = (k / 16) % 2;
        if (alt == 0 || f3 == 5 || (f3 == 0 && use_imm == 0)) begin
            rd  = 5'($random(seed));
            rs2 = 5'($random(seed));
            imm = 12'($random(seed));
            f7  = (alt == 1) ? 7'h20 : 7'h00;
            if (f3 == 1 || f3 == 5) begin
                imm = {f7, imm[4:0]}; // Shift amount with funct7
            end
            if (use_imm == 1) begin
                ins = i_format(imm, last_rd, 3'(f3), rd, OPCODE_OP_IMM);
            end else begin
                ins = r_format(f7, rs2, last_rd, 3'(f3), rd, OPCODE_OP);
            end
            drive_cycle(1'b1, ins, $sformatf("alu imm=%0d f3=%0d alt=%0d", use_imm, f3, alt));
            last_rd = rd; // Next one depends on this result
        end
    end
    drive_cycle(1'b0, '0, "idle");

    drive_cycle(1'b1, u_format(20'($random(seed)), 5'd7, OPCODE_LUI), "lui");
    drive_cycle(1'b1, u_format(20'($random(seed)), 5'd8, OPCODE_AUIPC), "auipc");
    drive_cycle(1'b1, u_format(20'($random(seed)), 5'd0, OPCODE_LUI), "lui_x0");
    drive_cycle(1'b1, r_format(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, OPCODE_OP), "read_x0");
    drive_cycle(1'b1, r_format(7'h00, 5'd7, 5'd0, 3'd6, 5'd10, OPCODE_OP), "or_x0");
    drive_cycle(1'b0, '0, "idle");

    for (int f = 0; f < 6; f++) begin
        if (f != 3) begin
            ins = i_format(12'($random(seed)), 5'($random(seed)), 3'(f), 5'd13, OPCODE_LOAD);
            drive_cycle(1'b1, ins, $sformatf("load f3=%0d", f));
        end
        if (f < 3) begin
            ins = s_format(12'($random(seed)), 5'($random(seed)), 5'($random(seed)), 3'(f));
            drive_cycle(1'b1, ins, $sformatf("store f3=%0d", f));
        end
    end
    drive_cycle(1'b0, '0, "idle");

    for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
            rs2 = 5'($random(seed));
            ins = b_format({12'($random(seed)), 1'b0}, rs2, rs2, 3'(f));
            drive_cycle(1'b1, ins, $sformatf("branch_same f3=%0d", f));
            ins = b_format({12'($random(seed)), 1'b0}, 5'($random(seed)), rs2, 3'(f));
            drive_cycle(1'b1, ins, $sformatf("branch_diff f3=%0d", f));
        end
    end
    drive_cycle(1'b1, j_format({20'($random(seed)), 1'b0}, 5'd11), "jal");
    ins = i_format(12'($random(seed)), 5'd11, 3'd0, 5'd12, OPCODE_JALR);
    drive_cycle(1'b1, ins, "jalr");
    drive_cycle(1'b0, '0, "idle");

    drive_cycle(1'b1, i_format(12'd0, 5'd0, 3'd0, 5'd0, OPCODE_SYSTEM), "ecall");
    drive_cycle(1'b1, r_format(7'h01, 5'd3, 5'd4, 3'd0, 5'd5, OPCODE_OP), "mul");
    drive_cycle(1'b1, i_format(12'($random(seed)), 5'd1, 3'd0, 5'd6, 7'h0b), "unknown_opcode");
    ins = i_format(12'($random(seed)), 5'd2, 3'd3, 5'd13, OPCODE_LOAD);
    drive_cycle(1'b1, ins, "load_bad_f3");
    ins = i_format(12'($random(seed)), 5'd2, 3'd1, 5'd12, OPCODE_JALR);
    drive_cycle(1'b1, ins, "jalr_bad_f3");
    drive_cycle(1'b1, r_format(7'h00, 5'd0, 5'd5, 3'd0, 5'd14, OPCODE_OP), "after_illegal");

    drive_cycle(1'b0, '0, "idle");
    drive_cycle(1'b0, '0, "idle_end");
    @(negedge clk);
    #1;
    $display("Test passed");
    $finish;
end

endmodule

// File: vlog.f
+incdir+.
segre_isa_pkg.sv
segre_core_pkg.sv
segre_ctrl_if.sv
segre_decode.sv
segre_rf.sv
segre_ex.sv
segre_core.sv
tb_segre_core.sv
